//--- Bender.yml
package:
  name: k423_core

sources:
  # package first, then the stages, then the top level
  - files:
      - common/k423_pkg.sv
      - logic/k423_fetch.sv
      - decode/k423_decode.sv
      - logic/k423_regfile.sv
      - execute/k423_execute.sv
      - logic/k423_result.sv
      - logic/k423_core.sv
  - target: test
    files:
      - tb/k423_core_asserts.sv
      - tb/k423_core_tb.sv

//--- common/k423_pkg.sv
// shared types, opcode and ALU operation constants, fetch state encoding

package k423_pkg;

  // ------------------------------------------------------------
  // widths fixed by RV32I
  // ------------------------------------------------------------
  // data word
  typedef logic [31:0] xlen_t;
  // byte address
  typedef logic [31:0] addr_t;
  // raw instruction word
  typedef logic [31:0] inst_t;
  // architectural register index
  typedef logic [4:0]  reg_idx_t;
  // ALU operation selector
  typedef logic [3:0]  alu_op_t;

  // ------------------------------------------------------------
  // ALU operations
  // ------------------------------------------------------------
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  // passes the U immediate through
  localparam alu_op_t ALU_LUI  = 4'd10;

  // ------------------------------------------------------------
  // major opcodes, inst[6:0]
  // ------------------------------------------------------------
  // register-register
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  // register-immediate
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // ------------------------------------------------------------
  // program counter
  // ------------------------------------------------------------
  localparam addr_t RESET_PC   = 32'h0000_0000;
  // no compressed instructions, so every step is one word
  localparam addr_t INST_BYTES = 32'd4;

  // ------------------------------------------------------------
  // fetch FSM
  // ------------------------------------------------------------
  // FETCH_REQ  request is being presented
  // FETCH_WAIT request accepted, response pending
  typedef enum logic [0:0] {
    FETCH_REQ  = 1'b0,
    FETCH_WAIT = 1'b1
  } fetch_state_e;

endpackage

//--- decode/k423_decode.sv
// instruction decoder and decode-to-execute pipeline register
`timescale 1ns/10ps

module k423_decode (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // from fetch
  input  logic                if_vld_i,
  input  k423_pkg::addr_t     if_pc_i,
  input  k423_pkg::inst_t     if_inst_i,
  // register file read
  input  k423_pkg::xlen_t     rs1_data_i,
  input  k423_pkg::xlen_t     rs2_data_i,
  output k423_pkg::reg_idx_t  rs1_idx_o,
  output k423_pkg::reg_idx_t  rs2_idx_o,
  // to execute
  output logic                id_vld_o,
  output k423_pkg::addr_t     id_pc_o,
  output k423_pkg::alu_op_t   id_alu_op_o,
  output logic                id_use_imm_o,
  output k423_pkg::xlen_t     id_imm_o,
  output k423_pkg::xlen_t     id_rs1_data_o,
  output k423_pkg::xlen_t     id_rs2_data_o,
  output logic                id_rd_vld_o,
  output k423_pkg::reg_idx_t  id_rd_idx_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               alt_bit;
  k423_pkg::reg_idx_t rd_idx;
  k423_pkg::alu_op_t  dec_alu_op;
  logic               dec_use_imm;
  logic               dec_rd_vld;
  k423_pkg::xlen_t    dec_imm;

  assign opcode  = if_inst_i[6:0];
  assign rd_idx  = if_inst_i[11:7];
  assign funct3  = if_inst_i[14:12];
  // inst[30] picks SUB and SRA/SRAI
  assign alt_bit = if_inst_i[30];

  assign rs1_idx_o = if_inst_i[19:15];
  assign rs2_idx_o = if_inst_i[24:20];

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  always_comb begin
    dec_alu_op  = k423_pkg::ALU_ADD;
    dec_use_imm = 1'b0;
    dec_rd_vld  = 1'b0;
    // I immediate, sign extended
    dec_imm     = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
    case (opcode)
      k423_pkg::OPC_OP, k423_pkg::OPC_OP_IMM: begin
        dec_use_imm = (opcode == k423_pkg::OPC_OP_IMM);
        dec_rd_vld  = 1'b1;
        case (funct3)
          3'b000: begin
            // no SUBI, so alt bit counts only for OP
            dec_alu_op = (alt_bit && !dec_use_imm) ? k423_pkg::ALU_SUB : k423_pkg::ALU_ADD;
          end
          3'b001:  dec_alu_op = k423_pkg::ALU_SLL;
          3'b010:  dec_alu_op = k423_pkg::ALU_SLT;
          3'b011:  dec_alu_op = k423_pkg::ALU_SLTU;
          3'b100:  dec_alu_op = k423_pkg::ALU_XOR;
          3'b101:  dec_alu_op = alt_bit ? k423_pkg::ALU_SRA : k423_pkg::ALU_SRL;
          3'b110:  dec_alu_op = k423_pkg::ALU_OR;
          default: dec_alu_op = k423_pkg::ALU_AND;
        endcase
      end
      k423_pkg::OPC_LUI: begin
        dec_alu_op  = k423_pkg::ALU_LUI;
        dec_use_imm = 1'b1;
        dec_rd_vld  = 1'b1;
        dec_imm     = {if_inst_i[31:12], 12'h000};
      end
      default: begin
        // unsupported, retires as a no-op
        dec_rd_vld = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // decode to execute register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_vld_o    <= 1'b0;
      id_rd_vld_o <= 1'b0;
    end else begin
      id_vld_o    <= if_vld_i;
      // x0 is never written
      id_rd_vld_o <= if_vld_i & dec_rd_vld & (rd_idx != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_vld_i) begin
      id_pc_o       <= if_pc_i;
      id_alu_op_o   <= dec_alu_op;
      id_use_imm_o  <= dec_use_imm;
      id_imm_o      <= dec_imm;
      id_rs1_data_o <= rs1_data_i;
      id_rs2_data_o <= rs2_data_i;
      id_rd_idx_o   <= rd_idx;
    end
  end

endmodule

//--- execute/k423_execute.sv
// operand selection and ALU for the execute stage
`timescale 1ns/10ps

module k423_execute (
  // from decode register
  input  logic                id_vld_i,
  input  k423_pkg::addr_t     id_pc_i,
  input  k423_pkg::alu_op_t   id_alu_op_i,
  input  logic                id_use_imm_i,
  input  k423_pkg::xlen_t     id_imm_i,
  input  k423_pkg::xlen_t     id_rs1_data_i,
  input  k423_pkg::xlen_t     id_rs2_data_i,
  input  logic                id_rd_vld_i,
  input  k423_pkg::reg_idx_t  id_rd_idx_i,
  // to result and forwarding
  output logic                ex_vld_o,
  output k423_pkg::addr_t     ex_pc_o,
  output logic                ex_rd_vld_o,
  output k423_pkg::reg_idx_t  ex_rd_idx_o,
  output k423_pkg::xlen_t     ex_rd_data_o
);

  k423_pkg::xlen_t op_a;
  k423_pkg::xlen_t op_b;
  logic [4:0]      shamt;

  assign op_a  = id_rs1_data_i;
  assign op_b  = id_use_imm_i ? id_imm_i : id_rs2_data_i;
  // shamt is the low five bits for both forms
  assign shamt = op_b[4:0];

  // ------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------
  always_comb begin
    case (id_alu_op_i)
      k423_pkg::ALU_ADD:  ex_rd_data_o = op_a + op_b;
      k423_pkg::ALU_SUB:  ex_rd_data_o = op_a - op_b;
      k423_pkg::ALU_SLL:  ex_rd_data_o = op_a << shamt;
      k423_pkg::ALU_SLT:  ex_rd_data_o = {31'd0, $signed(op_a) < $signed(op_b)};
      k423_pkg::ALU_SLTU: ex_rd_data_o = {31'd0, op_a < op_b};
      k423_pkg::ALU_XOR:  ex_rd_data_o = op_a ^ op_b;
      k423_pkg::ALU_SRL:  ex_rd_data_o = op_a >> shamt;
      k423_pkg::ALU_SRA:  ex_rd_data_o = k423_pkg::xlen_t'($signed(op_a) >>> shamt);
      k423_pkg::ALU_OR:   ex_rd_data_o = op_a | op_b;
      k423_pkg::ALU_AND:  ex_rd_data_o = op_a & op_b;
      // immediate already shifted up in decode
      k423_pkg::ALU_LUI:  ex_rd_data_o = id_imm_i;
      default:            ex_rd_data_o = '0;
    endcase
  end

  // ------------------------------------------------------------
  // stage outputs
  // ------------------------------------------------------------
  assign ex_vld_o    = id_vld_i;
  assign ex_pc_o     = id_pc_i;
  // keeps a stale rd_vld from forwarding in an empty cycle
  assign ex_rd_vld_o = id_vld_i & id_rd_vld_i;
  assign ex_rd_idx_o = id_rd_idx_i;

endmodule

//--- logic/k423_core.sv
// top level connecting fetch, decode, register file, execute and result
`timescale 1ns/10ps

module k423_core (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // instruction memory
  output logic                imem_req_vld_o,
  output k423_pkg::addr_t     imem_req_addr_o,
  input  logic                imem_req_rdy_i,
  input  logic                imem_rsp_vld_i,
  input  k423_pkg::inst_t     imem_rsp_rdata_i,
  // debug retirement
  output logic                debug_wb_vld_o,
  output k423_pkg::addr_t     debug_wb_pc_o,
  output logic                debug_wb_rd_vld_o,
  output k423_pkg::reg_idx_t  debug_wb_rd_idx_o,
  output k423_pkg::xlen_t     debug_wb_rd_o
);

  // ------------------------------------------------------------
  // stage wires
  // ------------------------------------------------------------
  logic               if_vld_w;
  k423_pkg::addr_t    if_pc_w;
  k423_pkg::inst_t    if_inst_w;

  k423_pkg::reg_idx_t rs1_idx_w;
  k423_pkg::reg_idx_t rs2_idx_w;
  k423_pkg::xlen_t    rs1_data_w;
  k423_pkg::xlen_t    rs2_data_w;

  logic               id_vld_w;
  k423_pkg::addr_t    id_pc_w;
  k423_pkg::alu_op_t  id_alu_op_w;
  logic               id_use_imm_w;
  k423_pkg::xlen_t    id_imm_w;
  k423_pkg::xlen_t    id_rs1_data_w;
  k423_pkg::xlen_t    id_rs2_data_w;
  logic               id_rd_vld_w;
  k423_pkg::reg_idx_t id_rd_idx_w;

  logic               ex_vld_w;
  k423_pkg::addr_t    ex_pc_w;
  logic               ex_rd_vld_w;
  k423_pkg::reg_idx_t ex_rd_idx_w;
  k423_pkg::xlen_t    ex_rd_data_w;

  logic               wb_vld_w;
  k423_pkg::addr_t    wb_pc_w;
  logic               wb_rd_vld_w;
  k423_pkg::reg_idx_t wb_rd_idx_w;
  k423_pkg::xlen_t    wb_rd_data_w;

  // writeback doubles as the debug port
  assign debug_wb_vld_o    = wb_vld_w;
  assign debug_wb_pc_o     = wb_pc_w;
  assign debug_wb_rd_vld_o = wb_rd_vld_w;
  assign debug_wb_rd_idx_o = wb_rd_idx_w;
  assign debug_wb_rd_o     = wb_rd_data_w;

  // ------------------------------------------------------------
  // stages
  // ------------------------------------------------------------
  k423_fetch u_k423_fetch (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .imem_req_rdy_i   ( imem_req_rdy_i   ),
    .imem_rsp_vld_i   ( imem_rsp_vld_i   ),
    .imem_rsp_rdata_i ( imem_rsp_rdata_i ),
    .imem_req_vld_o   ( imem_req_vld_o   ),
    .imem_req_addr_o  ( imem_req_addr_o  ),
    .if_vld_o         ( if_vld_w         ),
    .if_pc_o          ( if_pc_w          ),
    .if_inst_o        ( if_inst_w        )
  );

  k423_decode u_k423_decode (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .if_vld_i      ( if_vld_w      ),
    .if_pc_i       ( if_pc_w       ),
    .if_inst_i     ( if_inst_w     ),
    .rs1_data_i    ( rs1_data_w    ),
    .rs2_data_i    ( rs2_data_w    ),
    .rs1_idx_o     ( rs1_idx_w     ),
    .rs2_idx_o     ( rs2_idx_w     ),
    .id_vld_o      ( id_vld_w      ),
    .id_pc_o       ( id_pc_w       ),
    .id_alu_op_o   ( id_alu_op_w   ),
    .id_use_imm_o  ( id_use_imm_w  ),
    .id_imm_o      ( id_imm_w      ),
    .id_rs1_data_o ( id_rs1_data_w ),
    .id_rs2_data_o ( id_rs2_data_w ),
    .id_rd_vld_o   ( id_rd_vld_w   ),
    .id_rd_idx_o   ( id_rd_idx_w   )
  );

  k423_regfile u_k423_regfile (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .rs1_idx_i    ( rs1_idx_w    ),
    .rs2_idx_i    ( rs2_idx_w    ),
    .ex_vld_i     ( ex_vld_w     ),
    .ex_rd_vld_i  ( ex_rd_vld_w  ),
    .ex_rd_idx_i  ( ex_rd_idx_w  ),
    .ex_rd_data_i ( ex_rd_data_w ),
    .wb_vld_i     ( wb_vld_w     ),
    .wb_rd_vld_i  ( wb_rd_vld_w  ),
    .wb_rd_idx_i  ( wb_rd_idx_w  ),
    .wb_rd_data_i ( wb_rd_data_w ),
    .rs1_data_o   ( rs1_data_w   ),
    .rs2_data_o   ( rs2_data_w   )
  );

  k423_execute u_k423_execute (
    .id_vld_i      ( id_vld_w      ),
    .id_pc_i       ( id_pc_w       ),
    .id_alu_op_i   ( id_alu_op_w   ),
    .id_use_imm_i  ( id_use_imm_w  ),
    .id_imm_i      ( id_imm_w      ),
    .id_rs1_data_i ( id_rs1_data_w ),
    .id_rs2_data_i ( id_rs2_data_w ),
    .id_rd_vld_i   ( id_rd_vld_w   ),
    .id_rd_idx_i   ( id_rd_idx_w   ),
    .ex_vld_o      ( ex_vld_w      ),
    .ex_pc_o       ( ex_pc_w       ),
    .ex_rd_vld_o   ( ex_rd_vld_w   ),
    .ex_rd_idx_o   ( ex_rd_idx_w   ),
    .ex_rd_data_o  ( ex_rd_data_w  )
  );

  k423_result u_k423_result (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .ex_vld_i     ( ex_vld_w     ),
    .ex_pc_i      ( ex_pc_w      ),
    .ex_rd_vld_i  ( ex_rd_vld_w  ),
    .ex_rd_idx_i  ( ex_rd_idx_w  ),
    .ex_rd_data_i ( ex_rd_data_w ),
    .wb_vld_o     ( wb_vld_w     ),
    .wb_pc_o      ( wb_pc_w      ),
    .wb_rd_vld_o  ( wb_rd_vld_w  ),
    .wb_rd_idx_o  ( wb_rd_idx_w  ),
    .wb_rd_data_o ( wb_rd_data_w )
  );

endmodule

//--- logic/k423_fetch.sv
// program counter and instruction memory request/response sequencing
`timescale 1ns/10ps

module k423_fetch (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // instruction memory
  input  logic             imem_req_rdy_i,
  input  logic             imem_rsp_vld_i,
  input  k423_pkg::inst_t  imem_rsp_rdata_i,
  output logic             imem_req_vld_o,
  output k423_pkg::addr_t  imem_req_addr_o,
  // to decode
  output logic             if_vld_o,
  output k423_pkg::addr_t  if_pc_o,
  output k423_pkg::inst_t  if_inst_o
);

  k423_pkg::fetch_state_e state_q;
  k423_pkg::fetch_state_e state_d;
  k423_pkg::addr_t        pc_q;
  k423_pkg::addr_t        pc_nxt;
  logic                   rsp_hit;
  logic                   req_acc;

  // pc_q is the address of the outstanding (or pending) request
  assign pc_nxt  = pc_q + k423_pkg::INST_BYTES;
  assign rsp_hit = (state_q == k423_pkg::FETCH_WAIT) & imem_rsp_vld_i;
  assign req_acc = imem_req_vld_o & imem_req_rdy_i;

  // the next request may go out in the response cycle already
  // no request while reset is asserted
  assign imem_req_vld_o  = arst_n_i & ((state_q == k423_pkg::FETCH_REQ) | rsp_hit);
  assign imem_req_addr_o = rsp_hit ? pc_nxt : pc_q;

  always_comb begin
    state_d = state_q;
    if (state_q == k423_pkg::FETCH_REQ) begin
      if (req_acc) begin
        state_d = k423_pkg::FETCH_WAIT;
      end
    end else if (rsp_hit) begin
      // stay in wait if the early re-request got accepted
      state_d = req_acc ? k423_pkg::FETCH_WAIT : k423_pkg::FETCH_REQ;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= k423_pkg::FETCH_REQ;
      pc_q    <= k423_pkg::RESET_PC;
    end else begin
      state_q <= state_d;
      if (rsp_hit) begin
        pc_q <= pc_nxt;
      end
    end
  end

  // response word paired with the address it answers
  assign if_vld_o  = rsp_hit;
  assign if_pc_o   = pc_q;
  assign if_inst_o = imem_rsp_rdata_i;

endmodule

//--- logic/k423_regfile.sv
// integer register file x1..x31 with execute and writeback forwarding
`timescale 1ns/10ps

module k423_regfile (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // read ports
  input  k423_pkg::reg_idx_t  rs1_idx_i,
  input  k423_pkg::reg_idx_t  rs2_idx_i,
  // execute forwarding
  input  logic                ex_vld_i,
  input  logic                ex_rd_vld_i,
  input  k423_pkg::reg_idx_t  ex_rd_idx_i,
  input  k423_pkg::xlen_t     ex_rd_data_i,
  // writeback, forwarding and write port
  input  logic                wb_vld_i,
  input  logic                wb_rd_vld_i,
  input  k423_pkg::reg_idx_t  wb_rd_idx_i,
  input  k423_pkg::xlen_t     wb_rd_data_i,
  output k423_pkg::xlen_t     rs1_data_o,
  output k423_pkg::xlen_t     rs2_data_o
);

  k423_pkg::xlen_t regs_q [1:31];
  logic            ex_fwd;
  logic            wb_wr;

  assign ex_fwd = ex_vld_i & ex_rd_vld_i;
  assign wb_wr  = wb_vld_i & wb_rd_vld_i;

  // youngest producer wins: execute, then writeback, then array
  function automatic k423_pkg::xlen_t read_port(input k423_pkg::reg_idx_t idx);
    k423_pkg::xlen_t val;
    if (idx == '0) begin
      val = '0;
    end else if (ex_fwd && (ex_rd_idx_i == idx)) begin
      val = ex_rd_data_i;
    end else if (wb_wr && (wb_rd_idx_i == idx)) begin
      val = wb_rd_data_i;
    end else begin
      val = regs_q[idx];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_idx_i);
    rs2_data_o = read_port(rs2_idx_i);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_wr && (wb_rd_idx_i != '0)) begin
      regs_q[wb_rd_idx_i] <= wb_rd_data_i;
    end
  end

endmodule

//--- logic/k423_result.sv
// execute-to-writeback register feeding register file write and debug port
`timescale 1ns/10ps

module k423_result (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // from execute
  input  logic                ex_vld_i,
  input  k423_pkg::addr_t     ex_pc_i,
  input  logic                ex_rd_vld_i,
  input  k423_pkg::reg_idx_t  ex_rd_idx_i,
  input  k423_pkg::xlen_t     ex_rd_data_i,
  // writeback
  output logic                wb_vld_o,
  output k423_pkg::addr_t     wb_pc_o,
  output logic                wb_rd_vld_o,
  output k423_pkg::reg_idx_t  wb_rd_idx_o,
  output k423_pkg::xlen_t     wb_rd_data_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_vld_o    <= 1'b0;
      wb_rd_vld_o <= 1'b0;
    end else begin
      wb_vld_o    <= ex_vld_i;
      wb_rd_vld_o <= ex_vld_i & ex_rd_vld_i;
    end
  end

  // payload only moves with a valid instruction
  always_ff @(posedge clk_i) begin
    if (ex_vld_i) begin
      wb_pc_o      <= ex_pc_i;
      wb_rd_idx_o  <= ex_rd_idx_i;
      wb_rd_data_o <= ex_rd_data_i;
    end
  end

endmodule

//--- src.f
common/k423_pkg.sv
logic/k423_fetch.sv
decode/k423_decode.sv
logic/k423_regfile.sv
execute/k423_execute.sv
logic/k423_result.sv
logic/k423_core.sv
tb/k423_core_asserts.sv
tb/k423_core_tb.sv

//--- tb/k423_core_asserts.sv
// concurrent assertions on the fetch request port and the debug retirement port
`timescale 1ns/10ps

module k423_core_asserts (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_vld_i,
  input  logic                req_rdy_i,
  input  k423_pkg::addr_t     req_addr_i,
  input  logic                wb_vld_i,
  input  logic                wb_rd_vld_i,
  input  k423_pkg::reg_idx_t  wb_rd_idx_i
);

  // running failure count
  int assert_fails = 0;

  // ------------------------------------------------------------
  // fetch port
  // ------------------------------------------------------------
  // a stalled request keeps vld and its address
  req_addr_stable_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (req_vld_i && !req_rdy_i) |=> (req_vld_i && $stable(req_addr_i))
  ) else begin
    $error("stalled fetch request dropped vld or changed its address");
    assert_fails++;
  end

  // ------------------------------------------------------------
  // retirement port
  // ------------------------------------------------------------
  rd_vld_needs_vld_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wb_rd_vld_i |-> wb_vld_i
  ) else begin
    $error("debug rd_vld high without a retiring instruction");
    assert_fails++;
  end

  // x0 is never reported as written
  rd_idx_nonzero_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wb_rd_vld_i |-> (wb_rd_idx_i != '0)
  ) else begin
    $error("debug port reports a write to x0");
    assert_fails++;
  end

endmodule

bind k423_core k423_core_asserts u_k423_core_asserts (
  .clk_i       ( clk_i             ),
  .arst_n_i    ( arst_n_i          ),
  .req_vld_i   ( imem_req_vld_o    ),
  .req_rdy_i   ( imem_req_rdy_i    ),
  .req_addr_i  ( imem_req_addr_o   ),
  .wb_vld_i    ( debug_wb_vld_o    ),
  .wb_rd_vld_i ( debug_wb_rd_vld_o ),
  .wb_rd_idx_i ( debug_wb_rd_idx_o )
);

//--- tb/k423_core_tb.sv
// testbench for k423_core with memory model, ISA reference model and directed tests
`timescale 1ns/10ps

module k423_core_tb;

  // RV32I major opcodes as the ISA defines them
  localparam logic [6:0] OPC_R = 7'b0110011;
  localparam logic [6:0] OPC_I = 7'b0010011;
  localparam logic [6:0] OPC_U = 7'b0110111;
  localparam int MEM_WORDS = 256;
  localparam int RAND_LEN  = 64;

  logic               clk_i;
  logic               arst_n_i;
  logic               imem_req_vld_o;
  k423_pkg::addr_t    imem_req_addr_o;
  logic               imem_req_rdy_i;
  logic               imem_rsp_vld_i;
  k423_pkg::inst_t    imem_rsp_rdata_i;
  logic               debug_wb_vld_o;
  k423_pkg::addr_t    debug_wb_pc_o;
  logic               debug_wb_rd_vld_o;
  k423_pkg::reg_idx_t debug_wb_rd_idx_o;
  k423_pkg::xlen_t    debug_wb_rd_o;

  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] model_regs [0:31];
  logic [31:0] prog_q [$];
  logic [31:0] exp_pc [$];
  logic        exp_wr [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  longint      rsp_cyc [$];
  longint      cyc;
  longint      rsp_t;
  longint      cycle_limit;
  int          ret_cnt;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          total_errs;
  bit          checking;
  bit          stall_mode;
  // memory model state
  bit          pend;
  bit          in_rst;
  logic [31:0] pend_addr;
  logic [31:0] fetch_addr;
  int          wait_cnt;

  k423_core UUT (
    .clk_i             ( clk_i             ),
    .arst_n_i          ( arst_n_i          ),
    .imem_req_vld_o    ( imem_req_vld_o    ),
    .imem_req_addr_o   ( imem_req_addr_o   ),
    .imem_req_rdy_i    ( imem_req_rdy_i    ),
    .imem_rsp_vld_i    ( imem_rsp_vld_i    ),
    .imem_rsp_rdata_i  ( imem_rsp_rdata_i  ),
    .debug_wb_vld_o    ( debug_wb_vld_o    ),
    .debug_wb_pc_o     ( debug_wb_pc_o     ),
    .debug_wb_rd_vld_o ( debug_wb_rd_vld_o ),
    .debug_wb_rd_idx_o ( debug_wb_rd_idx_o ),
    .debug_wb_rd_o     ( debug_wb_rd_o     )
  );

  always #4 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // instruction memory with one outstanding request
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    in_rst = !arst_n_i;
    if (in_rst) begin
      pend       = 1'b0;
      fetch_addr = 32'h0;
    end else if (imem_req_vld_o && imem_req_rdy_i) begin
      // requests walk the word addresses in order from 0
      check_value("imem_req_addr_o", fetch_addr, imem_req_addr_o);
      fetch_addr = fetch_addr + 32'd4;
      pend       = 1'b1;
      pend_addr  = imem_req_addr_o;
      wait_cnt   = stall_mode ? int'($urandom % 4) : 0;
    end else if (pend && wait_cnt > 0) begin
      wait_cnt--;
    end
    #1;
    imem_req_rdy_i = !stall_mode || ($urandom % 4 != 0);
    imem_rsp_vld_i = 1'b0;
    if (pend && wait_cnt == 0) begin
      imem_rsp_vld_i   = 1'b1;
      imem_rsp_rdata_i = mem[pend_addr[9:2]];
      pend             = 1'b0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------------------
  // retirement monitor and cycle limit
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    if (checking) begin
      if (imem_rsp_vld_i) begin
        rsp_cyc.push_back(cyc);
      end
      if (debug_wb_vld_o) begin
        if (rsp_cyc.size() == 0) begin
          $display("retirement at pc %h has no matching memory response", debug_wb_pc_o);
          err_cnt++;
        end else begin
          rsp_t = rsp_cyc.pop_front();
          check_value("retire_latency", 32'd2, 32'(cyc - rsp_t));
        end
        if (ret_cnt < exp_pc.size()) begin
          check_value("debug_wb_pc_o", exp_pc[ret_cnt], debug_wb_pc_o);
          check_value("debug_wb_rd_vld_o", exp_wr[ret_cnt], debug_wb_rd_vld_o);
          if (exp_wr[ret_cnt]) begin
            check_value("debug_wb_rd_idx_o", exp_rd[ret_cnt], debug_wb_rd_idx_o);
            check_value("debug_wb_rd_o", exp_val[ret_cnt], debug_wb_rd_o);
          end
        end
        ret_cnt++;
      end
    end
    cyc++;
    if (cyc > cycle_limit) begin
      $display("timeout: no completion within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_I};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_R};
  endfunction

  function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OPC_U};
  endfunction

  // ISA semantics applied to the model register array
  task automatic model_exec(input logic [31:0] inst, output logic wr, output logic [4:0] rd,
                            output logic [31:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a   = model_regs[inst[19:15]];
    b   = {{20{inst[31]}}, inst[31:20]};
    rd  = inst[11:7];
    wr  = 1'b1;
    val = '0;
    if (inst[6:0] == OPC_R) begin
      b = model_regs[inst[24:20]];
    end
    sh = b[4:0];
    if (inst[6:0] == OPC_U) begin
      val = {inst[31:12], 12'h000};
    end else if (inst[6:0] == OPC_R || inst[6:0] == OPC_I) begin
      case (inst[14:12])
        3'b000: val = (inst[6:0] == OPC_R && inst[30]) ? a - b : a + b;
        3'b001: val = a << sh;
        3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: val = (a < b) ? 32'd1 : 32'd0;
        3'b100: val = a ^ b;
        3'b101: begin
          if (inst[30]) begin
            val = $signed(a) >>> sh;
          end else begin
            val = a >> sh;
          end
        end
        3'b110: val = a | b;
        default: val = a & b;
      endcase
    end else begin
      wr = 1'b0;
    end
    if (rd == 5'd0) begin
      wr = 1'b0;
    end
    if (wr) begin
      model_regs[rd] = val;
    end
  endtask

  task automatic apply_reset();
    arst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    // request and retirement outputs stay quiet in reset
    check_value("imem_req_vld_o", 32'd0, imem_req_vld_o);
    check_value("debug_wb_vld_o", 32'd0, debug_wb_vld_o);
    check_value("debug_wb_rd_vld_o", 32'd0, debug_wb_rd_vld_o);
    #1;
    arst_n_i = 1'b1;
  endtask

  // loads prog_q, resets the core and checks every retirement
  task automatic run_program(input string name, input bit stalls);
    logic        wr;
    logic [4:0]  rd;
    logic [31:0] val;
    int          errs_before;
    int          n;
    checking    = 1'b0;
    errs_before = err_cnt;
    n           = prog_q.size();
    exp_pc.delete();
    exp_wr.delete();
    exp_rd.delete();
    exp_val.delete();
    // unused words hold a custom-0 opcode tagged with their index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[24:0], 7'b0001011};
    end
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    foreach (prog_q[i]) begin
      mem[i] = prog_q[i];
      model_exec(prog_q[i], wr, rd, val);
      exp_pc.push_back(i * 4);
      exp_wr.push_back(wr);
      exp_rd.push_back(rd);
      exp_val.push_back(val);
    end
    cycle_limit += n * 10;
    stall_mode = stalls;
    apply_reset();
    rsp_cyc.delete();
    ret_cnt  = 0;
    checking = 1'b1;
    while (ret_cnt < n) begin
      @(posedge clk_i);
      #1;
    end
    checking = 1'b0;
    $display("%s: %0d instructions, %0d errors", name, n, err_cnt - errs_before);
    test_cnt++;
    prog_q.delete();
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_imm_chain();
    prog_q.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'd5));
    prog_q.push_back(enc_i(3'b000, 5'd2, 5'd1, -12));
    prog_q.push_back(enc_i(3'b100, 5'd3, 5'd2, 12'h7ff));
    prog_q.push_back(enc_i(3'b110, 5'd4, 5'd3, -256));
    prog_q.push_back(enc_i(3'b111, 5'd5, 5'd4, 12'h0f0));
    prog_q.push_back(enc_i(3'b010, 5'd6, 5'd2, -6));
    prog_q.push_back(enc_i(3'b011, 5'd7, 5'd2, -1));
    prog_q.push_back(enc_i(3'b001, 5'd8, 5'd2, 12'd4));
    prog_q.push_back(enc_i(3'b101, 5'd9, 5'd2, 12'd3));
    prog_q.push_back(enc_i(3'b101, 5'd10, 5'd2, 12'h403));
    prog_q.push_back(enc_i(3'b000, 5'd11, 5'd10, 12'h800));
    run_program("imm_chain", 1'b0);
  endtask

  task automatic test_reg_reg();
    prog_q.push_back(enc_i(3'b000, 5'd1, 5'd0, -100));
    prog_q.push_back(enc_i(3'b000, 5'd2, 5'd0, 12'd37));
    prog_q.push_back(enc_u(5'd3, 20'h80000));
    prog_q.push_back(enc_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h20, 3'b000, 5'd5, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h00, 3'b001, 5'd6, 5'd2, 5'd1));
    prog_q.push_back(enc_r(7'h00, 3'b010, 5'd7, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h00, 3'b011, 5'd8, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h00, 3'b100, 5'd9, 5'd1, 5'd3));
    prog_q.push_back(enc_r(7'h00, 3'b101, 5'd10, 5'd3, 5'd2));
    prog_q.push_back(enc_r(7'h20, 3'b101, 5'd11, 5'd3, 5'd2));
    prog_q.push_back(enc_r(7'h00, 3'b110, 5'd12, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h00, 3'b111, 5'd13, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h20, 3'b000, 5'd14, 5'd2, 5'd1));
    prog_q.push_back(enc_r(7'h00, 3'b010, 5'd15, 5'd3, 5'd1));
    run_program("reg_reg", 1'b0);
  endtask

  task automatic test_forwarding();
    prog_q.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'd1));
    prog_q.push_back(enc_i(3'b000, 5'd1, 5'd1, 12'd1));
    prog_q.push_back(enc_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
    prog_q.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
    // x0 writes must not forward
    prog_q.push_back(enc_i(3'b000, 5'd0, 5'd3, 12'd5));
    prog_q.push_back(enc_r(7'h00, 3'b000, 5'd4, 5'd0, 5'd3));
    prog_q.push_back(enc_r(7'h00, 3'b000, 5'd0, 5'd4, 5'd4));
    prog_q.push_back(enc_r(7'h20, 3'b000, 5'd5, 5'd4, 5'd0));
    prog_q.push_back(enc_r(7'h00, 3'b111, 5'd6, 5'd5, 5'd3));
    prog_q.push_back(enc_i(3'b001, 5'd7, 5'd6, 12'd31));
    run_program("forwarding", 1'b0);
  endtask

  task automatic test_lui_unsupported();
    prog_q.push_back(enc_u(5'd1, 20'habcde));
    prog_q.push_back(enc_u(5'd2, 20'h00001));
    prog_q.push_back(enc_i(3'b000, 5'd3, 5'd1, 12'h123));
    // jal x5 and lw x6 both retire as no-ops
    prog_q.push_back({20'h00000, 5'd5, 7'b1101111});
    prog_q.push_back({12'd0, 5'd1, 3'b010, 5'd6, 7'b0000011});
    prog_q.push_back(enc_r(7'h00, 3'b000, 5'd4, 5'd5, 5'd1));
    run_program("lui_unsupported", 1'b0);
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    for (int i = 0; i < RAND_LEN; i++) begin
      r   = $urandom;
      f3  = r[2:0];
      f7  = (r[12] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
      imm = r[31:20];
      if (f3 == 3'b001 || f3 == 3'b101) begin
        imm = {f7, r[24:20]};
      end
      // small register range keeps dependencies dense
      if (r[15:13] < 3) begin
        prog_q.push_back(enc_i(f3, {2'b00, r[5:3]}, {2'b00, r[8:6]}, imm));
      end else if (r[15:13] < 6) begin
        prog_q.push_back(enc_r(f7, f3, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]}));
      end else begin
        prog_q.push_back(enc_u({2'b00, r[5:3]}, r[31:12]));
      end
    end
    run_program("random_stalls", 1'b1);
  endtask

  initial begin
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    imem_req_rdy_i   = 1'b0;
    imem_rsp_vld_i   = 1'b0;
    imem_rsp_rdata_i = '0;
    checking         = 1'b0;
    stall_mode       = 1'b0;
    pend             = 1'b0;
    fetch_addr       = '0;
    cyc              = 0;
    cycle_limit      = 200;
    ret_cnt          = 0;
    err_cnt          = 0;
    check_cnt        = 0;
    test_cnt         = 0;
    void'($urandom(15453));
    @(posedge clk_i);
    #1;
    test_imm_chain();
    test_reg_reg();
    test_forwarding();
    test_lui_unsupported();
    test_random();
    total_errs = err_cnt + UUT.u_k423_core_asserts.assert_fails;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_cnt, check_cnt,
             err_cnt, UUT.u_k423_core_asserts.assert_fails);
    if (total_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
